/* list.f */
verilog/rv_decode_pkg.sv
verilog/ctrl_if.sv
verilog/maindec.sv
verilog/aludec.sv
verilog/controller.sv
verilog/immext.sv
verilog/decode_reg.sv
verilog/decode_top.sv
tests/tb_decode_top.sv

/* run.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module tb_decode_top -o sim_decode

out=$(./obj_dir/sim_decode 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "All tests passed!"

/* tests/decode_input.txt */
# Columns (hex): instr pc alu_ctrl result_src mem_write alu_src reg_write jump branch
#                store_type illegal imm rd rs1 rs2
002081B3 00001000 0 0 0 0 1 0 0 3 0 00000002 03 01 02
407302B3 00001004 1 0 0 0 1 0 0 3 0 00000407 05 06 07
003110B3 00001008 6 0 0 0 1 0 0 3 0 00000003 01 02 03
0062A233 0000100C 5 0 0 0 1 0 0 3 0 00000006 04 05 06
009443B3 00001010 4 0 0 0 1 0 0 3 0 00000009 07 08 09
00C5D533 00001014 7 0 0 0 1 0 0 3 0 0000000C 0A 0B 0C
00F766B3 00001018 3 0 0 0 1 0 0 3 0 0000000F 0D 0E 0F
0128F833 0000101C 2 0 0 0 1 0 0 3 0 00000012 10 11 12
FFF10093 00001020 0 0 0 1 1 0 0 3 0 FFFFFFFF 01 02 1F
40020193 00001024 0 0 0 1 1 0 0 3 0 00000400 03 04 00
7FF34293 00001028 4 0 0 1 1 0 0 3 0 000007FF 05 06 1F
00341393 0000102C 6 0 0 1 1 0 0 3 0 00000003 07 08 03
00455493 00001030 7 0 0 1 1 0 0 3 0 00000004 09 0A 04
FF862593 00001034 5 0 0 1 1 0 0 3 0 FFFFFFF8 0B 0C 18
0F00E093 00001038 3 0 0 1 1 0 0 3 0 000000F0 01 01 10
00812283 0000103C 0 1 0 1 1 0 0 3 0 00000008 05 02 08
FFC18303 00001040 0 1 0 1 1 0 0 3 0 FFFFFFFC 06 03 1C
00221383 00001044 0 1 0 1 1 0 0 3 0 00000002 07 04 02
00512623 00001048 0 0 1 1 0 0 0 0 0 0000000C 0C 02 05
FE619F23 0000104C 0 0 1 1 0 0 0 1 0 FFFFFFFE 1E 03 06
06720FA3 00001050 0 0 1 1 0 0 0 2 0 0000007F 1F 04 07
00208863 00001054 1 0 0 0 0 0 1 3 0 00000010 10 01 02
FE419CE3 00001058 1 0 0 0 0 0 1 3 0 FFFFFFF8 19 03 04
0062C0E3 0000105C 1 0 0 0 0 0 1 3 0 00000800 01 05 06
008000EF 00001060 0 2 0 0 1 1 0 3 0 00000008 01 00 08
FFDFF06F 00001064 0 2 0 0 1 1 0 3 0 FFFFFFFC 00 1F 1D
123450B7 00001068 0 0 0 0 0 0 0 3 1 00000123 01 08 03
00000117 0000106C 0 0 0 0 0 0 0 3 1 00000000 02 00 00
000280E7 00001070 0 0 0 0 0 0 0 3 1 00000000 01 05 00
403150B3 00001074 7 0 0 0 0 0 0 3 1 00000403 01 02 03
4022D213 00001078 7 0 0 1 0 0 0 3 1 00000402 04 05 02
0083B333 0000107C 0 0 0 0 0 0 0 3 1 00000008 06 07 08
00553493 00001080 0 0 0 1 0 0 0 3 1 00000005 09 0A 05
00513023 00001084 0 0 0 1 0 0 0 3 1 00000000 00 02 05
00000000 00001088 0 0 0 0 0 0 0 3 1 00000000 00 00 00

/* tests/tb_decode_top.sv */
/*
    Testbench for decode_top. Vectors come from tests/decode_input.txt,
    run from the project root. First pass uses random gaps and random
    i_ready; second pass streams with i_ready high and checks latency.
*/
`timescale 1ns/1ns
module tb_decode_top;
    import rv_decode_pkg::*;

    localparam int WAIT_LIMIT = 400;            // Cycles per wait loop

    logic i_clk, i_rst_n, i_valid, i_ready, o_ready, o_valid;
    word_t i_instr, i_pc, o_imm, o_pc;
    alu_op_t o_alu_ctrl;
    result_src_t o_result_src;
    store_t o_store_type;
    logic o_mem_write, o_alu_src, o_reg_write, o_jump, o_branch, o_illegal;
    reg_idx_t o_rd, o_rs1, o_rs2;

    word_t v_instr[$], v_pc[$], v_imm[$];       // Vectors from file
    alu_op_t v_alu[$];
    result_src_t v_res[$];
    store_t v_st[$];
    logic v_mw[$], v_as[$], v_rw[$], v_j[$], v_b[$], v_ill[$];
    reg_idx_t v_rd[$], v_rs1[$], v_rs2[$];

    int exp_q[$];                               // Pending vector indices
    int hs_q[$];                                // Input handshake cycles
    int cyc = 0;
    int n_done = 0;
    int idx, hs;
    bit mon_on = 0, phase_b = 0, stalled = 0;

    decode_top decode_top_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_valid(i_valid), .i_instr(i_instr),
        .i_pc(i_pc), .o_ready(o_ready), .o_valid(o_valid), .i_ready(i_ready),
        .o_alu_ctrl(o_alu_ctrl), .o_result_src(o_result_src), .o_mem_write(o_mem_write),
        .o_alu_src(o_alu_src), .o_reg_write(o_reg_write), .o_jump(o_jump),
        .o_branch(o_branch), .o_store_type(o_store_type), .o_illegal(o_illegal),
        .o_imm(o_imm), .o_pc(o_pc), .o_rd(o_rd), .o_rs1(o_rs1), .o_rs2(o_rs2)
    );

    initial begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;             // 40 ns period
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_alu(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic check_res(input string name, input result_src_t got, input result_src_t exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic check_store(input string name, input store_t got, input store_t exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_now($sformatf("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    endtask

    task automatic read_vectors();
        int fd, n;
        string line;
        logic [31:0] f[15];
        fd = $fopen("tests/decode_input.txt", "r");
        if (fd == 0)
            fail_now("Could not open tests/decode_input.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                        f[9], f[10], f[11], f[12], f[13], f[14]);
            if (n == 15) begin                  // Comment lines give 0
                v_instr.push_back(f[0]);
                v_pc.push_back(f[1]);
                v_alu.push_back(alu_op_t'(f[2][2:0]));
                v_res.push_back(result_src_t'(f[3][1:0]));
                v_mw.push_back(f[4][0]);
                v_as.push_back(f[5][0]);
                v_rw.push_back(f[6][0]);
                v_j.push_back(f[7][0]);
                v_b.push_back(f[8][0]);
                v_st.push_back(store_t'(f[9][1:0]));
                v_ill.push_back(f[10][0]);
                v_imm.push_back(f[11]);
                v_rd.push_back(f[12][4:0]);
                v_rs1.push_back(f[13][4:0]);
                v_rs2.push_back(f[14][4:0]);
            end
        end
        $fclose(fd);
        if (v_instr.size() == 0)
            fail_now("No vectors found in tests/decode_input.txt");
    endtask

    task automatic check_vector(input int k);
        check_alu("o_alu_ctrl", o_alu_ctrl, v_alu[k]);
        check_res("o_result_src", o_result_src, v_res[k]);
        check_bit("o_mem_write", o_mem_write, v_mw[k]);
        check_bit("o_alu_src", o_alu_src, v_as[k]);
        check_bit("o_reg_write", o_reg_write, v_rw[k]);
        check_bit("o_jump", o_jump, v_j[k]);
        check_bit("o_branch", o_branch, v_b[k]);
        check_store("o_store_type", o_store_type, v_st[k]);
        check_bit("o_illegal", o_illegal, v_ill[k]);
        check_word("o_imm", o_imm, v_imm[k]);
        check_word("o_pc", o_pc, v_pc[k]);
        check_idx("o_rd", o_rd, v_rd[k]);
        check_idx("o_rs1", o_rs1, v_rs1[k]);
        check_idx("o_rs2", o_rs2, v_rs2[k]);
    endtask

    // Enters and leaves on a rising edge
    task automatic drive_all(input bit gaps);
        int gap, waited;
        for (int k = 0; k < v_instr.size(); k++) begin
            gap = gaps ? int'($urandom_range(0, 2)) : 0;
            if (gap > 0) begin
                i_valid <= 1'b0;
                repeat (gap) @(posedge i_clk);
            end
            i_valid <= 1'b1;
            i_instr <= v_instr[k];
            i_pc    <= v_pc[k];
            waited = 0;
            do begin
                @(negedge i_clk);
                waited++;
                if (waited > WAIT_LIMIT)
                    fail_now("Timed out waiting for o_ready");
            end while (!o_ready);
            exp_q.push_back(k);
            hs_q.push_back(cyc + 1);            // Handshake on next edge
            @(posedge i_clk);
        end
        i_valid <= 1'b0;
    endtask

    task automatic wait_drained(input int total);
        int waited;
        waited = 0;
        while (n_done < total) begin
            @(negedge i_clk);
            waited++;
            if (waited > WAIT_LIMIT)
                fail_now("Timed out waiting for outputs to drain");
        end
    endtask

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (phase_b)
            i_ready <= 1'b1;
        else if (mon_on)
            i_ready <= ($urandom_range(0, 3) != 0); // Ready 3 of 4 cycles
    end

    // Sample between edges, where every output is settled
    always @(negedge i_clk) begin
        if (mon_on) begin
            if (o_valid && !i_ready)
                check_bit("o_ready", o_ready, 1'b0);    // Full and blocked
            else
                check_bit("o_ready", o_ready, 1'b1);    // Empty or draining
            if (stalled)
                check_bit("o_valid", o_valid, 1'b1);
            if (o_valid) begin
                if (exp_q.size() == 0)
                    fail_now("DUT presented an output with no instruction pending");
                check_vector(exp_q[0]);                 // Held entry matches as well
                if (i_ready) begin
                    idx = exp_q.pop_front();
                    hs  = hs_q.pop_front();
                    if (phase_b && cyc + 1 != hs + 1)
                        fail_now($sformatf("Instruction %0d left %0d cycles after its handshake",
                                           idx, cyc + 1 - hs));
                    n_done++;
                end
            end
            stalled = o_valid && !i_ready;
        end
    end

    initial begin
        i_rst_n = 1'b0;
        i_valid = 1'b0;
        i_ready = 1'b0;
        i_instr = '0;
        i_pc    = '0;
        void'($urandom(46));
        read_vectors();
        repeat (16) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check_bit("o_valid", o_valid, 1'b0);    // Clean state after reset
        check_bit("o_mem_write", o_mem_write, 1'b0);
        check_bit("o_reg_write", o_reg_write, 1'b0);
        check_bit("o_jump", o_jump, 1'b0);
        check_bit("o_branch", o_branch, 1'b0);
        mon_on = 1'b1;
        @(posedge i_clk);
        drive_all(1'b1);
        wait_drained(v_instr.size());
        phase_b = 1'b1;                         // Full rate streaming
        @(posedge i_clk);
        drive_all(1'b0);
        wait_drained(2 * v_instr.size());
        repeat (4) @(negedge i_clk);            // Idle tail, no stray output
        $display("All tests passed!");
        $finish;
    end

endmodule

/* verilog/aludec.sv */
/*
    ALU decoder, purely combinational.
    SRA/SRAI and SLTU/SLTIU are not supported and are flagged illegal.
*/
`timescale 1ns/1ns
module aludec (
    input  rv_decode_pkg::aluop_class_t i_aluop,    // From main decoder
    input  logic [2:0]                  i_funct3,
    input  logic                        i_funct7b5, // funct7 bit 5
    input  logic                        i_opb5,     // Opcode bit 5, 1 = R-type
    output rv_decode_pkg::alu_op_t      o_alu_ctrl,
    output logic                        o_illegal
);
    import rv_decode_pkg::*;

    always_comb begin
        o_alu_ctrl = ALU_ADD;
        o_illegal  = 1'b0;
        case (i_aluop)
            ACL_ADD: o_alu_ctrl = ALU_ADD;      // Load/store address
            ACL_SUB: o_alu_ctrl = ALU_SUB;      // Branch compare
            ACL_FUNC: begin
                case (i_funct3)
                    3'b000:  o_alu_ctrl = (i_opb5 && i_funct7b5) ? ALU_SUB : ALU_ADD;
                    3'b001:  o_alu_ctrl = ALU_SLL;
                    3'b010:  o_alu_ctrl = ALU_SLT;
                    3'b100:  o_alu_ctrl = ALU_XOR;
                    3'b101: begin
                        o_alu_ctrl = ALU_SRL;
                        o_illegal  = i_funct7b5; // SRA / SRAI
                    end
                    3'b110:  o_alu_ctrl = ALU_OR;
                    3'b111:  o_alu_ctrl = ALU_AND;
                    default: o_illegal  = 1'b1;  // SLTU / SLTIU
                endcase
            end
            default: o_illegal = 1'b1;          // Unused class code
        endcase
    end

endmodule

/* verilog/controller.sv */
/*
    Control unit: main decoder plus ALU decoder.
    An illegal instruction has reg_write, mem_write, jump and branch forced low,
    so it never has side effects downstream.
*/
`timescale 1ns/1ns
module controller (
    input  rv_decode_pkg::opcode_t i_op,
    input  logic [2:0]             i_funct3,
    input  logic                   i_funct7b5,
    ctrl_if.src                    ctrl         // Decoded bundle out
);
    import rv_decode_pkg::*;

    aluop_class_t aluop;                        // Main to ALU decoder
    logic         md_illegal;
    logic         ad_illegal;
    logic         md_mem_write;                 // Ungated enables
    logic         md_reg_write;
    logic         md_jump;
    logic         md_branch;
    logic         illegal;

    maindec u_maindec (
        .i_op         (i_op),
        .i_funct3     (i_funct3),
        .o_result_src (ctrl.result_src),
        .o_imm_src    (ctrl.imm_src),
        .o_mem_write  (md_mem_write),
        .o_alu_src    (ctrl.alu_src),
        .o_reg_write  (md_reg_write),
        .o_jump       (md_jump),
        .o_branch     (md_branch),
        .o_aluop      (aluop),
        .o_store_type (ctrl.store_type),
        .o_illegal    (md_illegal)
    );

    aludec u_aludec (
        .i_aluop    (aluop),
        .i_funct3   (i_funct3),
        .i_funct7b5 (i_funct7b5),
        .i_opb5     (i_op[5]),                  // Splits SUB from ADDI
        .o_alu_ctrl (ctrl.alu_ctrl),
        .o_illegal  (ad_illegal)
    );

    assign illegal        = md_illegal | ad_illegal;
    assign ctrl.illegal   = illegal;
    assign ctrl.mem_write = md_mem_write & ~illegal; // Kill side effects
    assign ctrl.reg_write = md_reg_write & ~illegal;
    assign ctrl.jump      = md_jump & ~illegal;
    assign ctrl.branch    = md_branch & ~illegal;

endmodule

/* verilog/ctrl_if.sv */
/*
    Decoded control bundle between the controller and its consumers.
    src drives the bundle; dst is shared by the extender and the pipeline register.
*/
`timescale 1ns/1ns
interface ctrl_if;
    import rv_decode_pkg::*;

    alu_op_t     alu_ctrl;                      // ALU operation
    result_src_t result_src;                    // Writeback mux select
    imm_src_t    imm_src;                       // Immediate format
    logic        mem_write;                     // Data memory write enable
    logic        alu_src;                       // 1 = immediate operand
    logic        reg_write;                     // Register file write enable
    logic        jump;
    logic        branch;
    store_t      store_type;                    // Store width
    logic        illegal;                       // Unsupported encoding

    modport src (
        output alu_ctrl, result_src, imm_src, mem_write, alu_src,
               reg_write, jump, branch, store_type, illegal
    );

    modport dst (
        input  alu_ctrl, result_src, imm_src, mem_write, alu_src,
               reg_write, jump, branch, store_type, illegal
    );

endinterface

/* verilog/decode_reg.sv */
/*
    One-entry decode-to-execute register with valid/ready on both sides.
    Accepts when empty or when the held entry leaves in the same cycle,
    so throughput is one per cycle and latency exactly one cycle.
    Reset clears valid and all control fields; payload fields are not reset.
*/
`timescale 1ns/1ns
module decode_reg (
    input  logic                        i_clk,
    input  logic                        i_rst_n,      // Sync, active low
    input  logic                        i_valid,      // Upstream handshake
    output logic                        o_ready,
    ctrl_if.dst                         ctrl,         // From controller
    input  rv_decode_pkg::word_t        i_imm,
    input  rv_decode_pkg::word_t        i_pc,
    input  rv_decode_pkg::reg_idx_t     i_rd,
    input  rv_decode_pkg::reg_idx_t     i_rs1,
    input  rv_decode_pkg::reg_idx_t     i_rs2,
    output logic                        o_valid,      // Downstream handshake
    input  logic                        i_ready,
    output rv_decode_pkg::alu_op_t      o_alu_ctrl,
    output rv_decode_pkg::result_src_t  o_result_src,
    output logic                        o_mem_write,
    output logic                        o_alu_src,
    output logic                        o_reg_write,
    output logic                        o_jump,
    output logic                        o_branch,
    output rv_decode_pkg::store_t       o_store_type,
    output logic                        o_illegal,
    output rv_decode_pkg::word_t        o_imm,
    output rv_decode_pkg::word_t        o_pc,
    output rv_decode_pkg::reg_idx_t     o_rd,
    output rv_decode_pkg::reg_idx_t     o_rs1,
    output rv_decode_pkg::reg_idx_t     o_rs2
);
    import rv_decode_pkg::*;

    logic load;                                 // Upstream transfer this edge

    assign o_ready = ~o_valid | i_ready;        // Empty or draining
    assign load    = i_valid & o_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid      <= 1'b0;
            o_alu_ctrl   <= ALU_ADD;
            o_result_src <= RES_ALU;
            o_mem_write  <= 1'b0;
            o_alu_src    <= 1'b0;
            o_reg_write  <= 1'b0;
            o_jump       <= 1'b0;
            o_branch     <= 1'b0;
            o_store_type <= ST_WORD;
            o_illegal    <= 1'b0;
        end else begin
            if (o_ready)
                o_valid <= i_valid;             // Refill or go empty
            if (load) begin
                o_alu_ctrl   <= ctrl.alu_ctrl;
                o_result_src <= ctrl.result_src;
                o_mem_write  <= ctrl.mem_write;
                o_alu_src    <= ctrl.alu_src;
                o_reg_write  <= ctrl.reg_write;
                o_jump       <= ctrl.jump;
                o_branch     <= ctrl.branch;
                o_store_type <= ctrl.store_type;
                o_illegal    <= ctrl.illegal;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (load) begin
            o_imm <= i_imm;                     // Payload, no reset
            o_pc  <= i_pc;
            o_rd  <= i_rd;
            o_rs1 <= i_rs1;
            o_rs2 <= i_rs2;
        end
    end

    // Stalled entry holds all fields until it is taken
    a_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (o_valid && !i_ready) |=> o_valid && $stable({o_alu_ctrl, o_result_src,
            o_mem_write, o_alu_src, o_reg_write, o_jump, o_branch, o_store_type,
            o_illegal, o_imm, o_pc, o_rd, o_rs1, o_rs2}));

    a_reset: assert property (@(posedge i_clk) !i_rst_n |=> !o_valid);

endmodule

/* verilog/decode_top.sv */
/*
    RV32I decode stage top level.
    Plain ports on both handshakes; one cycle from input handshake to o_valid.
    No register file or hazard logic here; rd/rs1/rs2 are passed through.
*/
`timescale 1ns/1ns
module decode_top (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_valid,
    input  rv_decode_pkg::word_t        i_instr,      // Fetched word
    input  rv_decode_pkg::word_t        i_pc,
    output logic                        o_ready,
    output logic                        o_valid,
    input  logic                        i_ready,      // Execute can take it
    output rv_decode_pkg::alu_op_t      o_alu_ctrl,
    output rv_decode_pkg::result_src_t  o_result_src,
    output logic                        o_mem_write,
    output logic                        o_alu_src,
    output logic                        o_reg_write,
    output logic                        o_jump,
    output logic                        o_branch,
    output rv_decode_pkg::store_t       o_store_type,
    output logic                        o_illegal,
    output rv_decode_pkg::word_t        o_imm,
    output rv_decode_pkg::word_t        o_pc,
    output rv_decode_pkg::reg_idx_t     o_rd,
    output rv_decode_pkg::reg_idx_t     o_rs1,
    output rv_decode_pkg::reg_idx_t     o_rs2
);
    import rv_decode_pkg::*;

    opcode_t  opcode;
    reg_idx_t rd, rs1, rs2;
    word_t    imm;

    assign opcode = i_instr[6:0];               // Instruction fields
    assign rd     = i_instr[11:7];
    assign rs1    = i_instr[19:15];
    assign rs2    = i_instr[24:20];

    ctrl_if ctrl_bus ();

    controller u_controller (
        .i_op       (opcode),
        .i_funct3   (i_instr[14:12]),
        .i_funct7b5 (i_instr[30]),
        .ctrl       (ctrl_bus)
    );

    immext u_immext (
        .i_instr (i_instr),
        .ctrl    (ctrl_bus),
        .o_imm   (imm)
    );

    decode_reg u_decode_reg (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .ctrl         (ctrl_bus),
        .i_imm        (imm),
        .i_pc         (i_pc),
        .i_rd         (rd),
        .i_rs1        (rs1),
        .i_rs2        (rs2),
        .o_valid      (o_valid),
        .i_ready      (i_ready),
        .o_alu_ctrl   (o_alu_ctrl),
        .o_result_src (o_result_src),
        .o_mem_write  (o_mem_write),
        .o_alu_src    (o_alu_src),
        .o_reg_write  (o_reg_write),
        .o_jump       (o_jump),
        .o_branch     (o_branch),
        .o_store_type (o_store_type),
        .o_illegal    (o_illegal),
        .o_imm        (o_imm),
        .o_pc         (o_pc),
        .o_rd         (o_rd),
        .o_rs1        (o_rs1),
        .o_rs2        (o_rs2)
    );

endmodule

/* verilog/immext.sv */
/*
    Immediate extender for the I, S, B and J formats.
    Always sign-extends from instruction bit 31; B and J have bit 0 cleared.
*/
`timescale 1ns/1ns
module immext (
    input  rv_decode_pkg::word_t i_instr,       // Full instruction word
    ctrl_if.dst                  ctrl,          // Only imm_src is used
    output rv_decode_pkg::word_t o_imm
);
    import rv_decode_pkg::*;

    always_comb begin
        case (ctrl.imm_src)
            IMM_I: o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            IMM_S: o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            IMM_B: o_imm = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25],
                            i_instr[11:8], 1'b0};               // 13-bit offset
            IMM_J: o_imm = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20],
                            i_instr[30:21], 1'b0};              // 21-bit offset
            default: o_imm = '0;
        endcase
    end

endmodule

/* verilog/maindec.sv */
/*
    Main decoder, purely combinational.
    Unknown opcodes raise o_illegal with every write enable off.
    Load funct3 is not checked; store funct3 above 2 is illegal.
*/
`timescale 1ns/1ns
module maindec (
    input  rv_decode_pkg::opcode_t      i_op,           // 7-bit opcode
    input  logic [2:0]                  i_funct3,       // Store width select
    output rv_decode_pkg::result_src_t  o_result_src,   // Writeback source
    output rv_decode_pkg::imm_src_t     o_imm_src,      // Immediate format
    output logic                        o_mem_write,
    output logic                        o_alu_src,      // Reg or immediate
    output logic                        o_reg_write,
    output logic                        o_jump,
    output logic                        o_branch,
    output rv_decode_pkg::aluop_class_t o_aluop,        // Class for aludec
    output rv_decode_pkg::store_t       o_store_type,
    output logic                        o_illegal
);
    import rv_decode_pkg::*;

    always_comb begin
        o_result_src = RES_ALU;                 // Defaults: a no-op
        o_imm_src    = IMM_I;
        o_mem_write  = 1'b0;
        o_alu_src    = 1'b0;
        o_reg_write  = 1'b0;
        o_jump       = 1'b0;
        o_branch     = 1'b0;
        o_aluop      = ACL_ADD;
        o_store_type = ST_NONE;
        o_illegal    = 1'b0;
        case (i_op)
            OP_LOAD: begin
                o_result_src = RES_MEM;         // Data from memory
                o_alu_src    = 1'b1;            // rs1 + imm
                o_reg_write  = 1'b1;
            end
            OP_STORE: begin
                o_imm_src   = IMM_S;
                o_alu_src   = 1'b1;
                o_mem_write = 1'b1;
                case (i_funct3)
                    3'b000:  o_store_type = ST_BYTE;
                    3'b001:  o_store_type = ST_HALF;
                    3'b010:  o_store_type = ST_WORD;
                    default: begin
                        o_mem_write = 1'b0;     // No width to write
                        o_illegal   = 1'b1;
                    end
                endcase
            end
            OP_RTYPE: begin
                o_reg_write = 1'b1;
                o_aluop     = ACL_FUNC;
            end
            OP_ITYPE: begin
                o_alu_src   = 1'b1;
                o_reg_write = 1'b1;
                o_aluop     = ACL_FUNC;
            end
            OP_BRANCH: begin
                o_imm_src = IMM_B;
                o_branch  = 1'b1;
                o_aluop   = ACL_SUB;            // Compare by subtract
            end
            OP_JAL: begin
                o_imm_src    = IMM_J;
                o_result_src = RES_PC4;         // Link address
                o_reg_write  = 1'b1;
                o_jump       = 1'b1;
            end
            default: o_illegal = 1'b1;
        endcase
    end

endmodule

/* verilog/rv_decode_pkg.sv */
/*
    Shared types and opcodes for the RV32I decode stage.
    Only the six supported opcodes are listed; anything else decodes as illegal.
    Enum values are fixed so testbench vectors can use raw numbers.
*/
package rv_decode_pkg;

    localparam int XLEN  = 32;                  // Data path width
    localparam int REG_W = 5;                   // Register index width

    typedef logic [XLEN-1:0]  word_t;           // Instr, PC, immediate
    typedef logic [REG_W-1:0] reg_idx_t;        // rd / rs1 / rs2
    typedef logic [6:0]       opcode_t;

    localparam opcode_t OP_LOAD   = 7'b0000011; // LW/LH/LB
    localparam opcode_t OP_STORE  = 7'b0100011; // SW/SH/SB
    localparam opcode_t OP_RTYPE  = 7'b0110011;
    localparam opcode_t OP_ITYPE  = 7'b0010011; // Immediate ALU ops
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_SRL = 3'd7
    } alu_op_t;

    typedef enum logic [1:0] {
        ACL_ADD  = 2'd0,                        // Address add
        ACL_SUB  = 2'd1,                        // Branch compare
        ACL_FUNC = 2'd2                         // Look at funct fields
    } aluop_class_t;

    typedef enum logic [1:0] {RES_ALU = 2'd0, RES_MEM = 2'd1, RES_PC4 = 2'd2} result_src_t;
    typedef enum logic [1:0] {IMM_I = 2'd0, IMM_S = 2'd1, IMM_B = 2'd2, IMM_J = 2'd3} imm_src_t;

    // 00 word, 01 half, 10 byte, 11 not a store
    typedef enum logic [1:0] {
        ST_WORD = 2'd0,
        ST_HALF = 2'd1,
        ST_BYTE = 2'd2,
        ST_NONE = 2'd3
    } store_t;

endpackage
